// File: hw/spi_mem_pkg.sv
package spi_mem_pkg;

    localparam int unsigned ADDR_W = 26;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned NIB_W  = 4;

    // nibbles in one 32-bit frame
    localparam int unsigned FRAME_NIBS = DATA_W / NIB_W;

    localparam logic [7:0] CMD_READ  = 8'h0A;
    localparam logic [7:0] CMD_WRITE = 8'h02;

    // in SPI clocks, two clk_i cycles each
    localparam int unsigned DEF_LAT_CLOCKS = 3;

    typedef enum logic {
        SIZE_BYTE = 1'b0,
        SIZE_WORD = 1'b1
    } bus_size_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        bus_size_e         size;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } mem_rsp_t;

    // row/column split of the 26-bit RAM address
    typedef struct packed {
        logic [2:0]  pad_hi;
        logic [15:0] row;
        logic        rsvd;
        logic [9:0]  col;
        logic [1:0]  pad_lo;
    } addr_fields_t;

    // same word seen as sent on the wire, nib[7] goes out first
    typedef union packed {
        addr_fields_t                     fields;
        logic [FRAME_NIBS-1:0][NIB_W-1:0] nib;
    } addr_frame_u;

endpackage

// File: hw/spi_tx_shifter.sv
`timescale 1ns/1ps

module spi_tx_shifter (
    input  logic                           clk_i,
    input  logic                           nrst_i,

    input  logic                           load_i,
    input  logic [spi_mem_pkg::DATA_W-1:0] frame_i,
    input  logic [3:0]                     count_i,

    output logic [spi_mem_pkg::NIB_W-1:0]  sio_o,
    output logic                           done_o
);

    localparam int unsigned DW = spi_mem_pkg::DATA_W;
    localparam int unsigned NW = spi_mem_pkg::NIB_W;

    logic [DW-1:0] shift_q;
    logic [3:0]    left_q;
    logic          last;

    // last nibble is on the lines this cycle
    assign last = (left_q == 4'd1);

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            shift_q <= '0;
            left_q  <= '0;
        end else if (load_i) begin
            shift_q <= frame_i;
            left_q  <= count_i;
        end else if (left_q != 4'd0) begin
            left_q <= left_q - 4'd1;
            if (last) begin
                // idle lines read as zero until the next frame
                shift_q <= '0;
            end else begin
                shift_q <= {shift_q[DW-NW-1:0], {NW{1'b0}}};
            end
        end
    end

    // msb nibble leads
    assign sio_o  = shift_q[DW-1 -: NW];
    assign done_o = last;

endmodule

// File: hw/spi_rx_gather.sv
`timescale 1ns/1ps

module spi_rx_gather (
    input  logic                           clk_i,
    input  logic                           nrst_i,

    input  logic                           start_i,
    input  logic [3:0]                     count_i,
    input  logic [spi_mem_pkg::NIB_W-1:0]  sio_i,
    input  logic                           dqs_i,

    output logic [spi_mem_pkg::DATA_W-1:0] word_o,
    output logic                           done_o
);

    localparam int unsigned DW    = spi_mem_pkg::DATA_W;
    localparam int unsigned NW    = spi_mem_pkg::NIB_W;
    localparam int unsigned POS_W = $clog2(DW);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_WAIT,
        RX_CAPT
    } rx_state_e;

    rx_state_e        state_q;
    logic [2:0]       idx_q;
    logic [3:0]       count_q;
    logic [DW-1:0]    word_q;
    logic             done_q;

    logic             capture;
    logic             last;
    logic [POS_W-1:0] pos;

    // first capture happens in the cycle dqs is seen high
    assign capture = ((state_q == RX_WAIT) && dqs_i) || (state_q == RX_CAPT);
    assign last    = ({1'b0, idx_q} == (count_q - 4'd1));

    // byte lane from idx[2:1], even index is the high nibble
    assign pos = {idx_q[2:1], ~idx_q[0], 2'b00};

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state_q <= RX_IDLE;
            idx_q   <= '0;
            count_q <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                state_q <= RX_WAIT;
                idx_q   <= '0;
                count_q <= count_i;
            end else if (capture) begin
                if (last) begin
                    state_q <= RX_IDLE;
                    done_q  <= 1'b1;
                end else begin
                    state_q <= RX_CAPT;
                    idx_q   <= idx_q + 3'd1;
                end
            end
        end
    end

    // unfilled lanes stay zero, so a byte read comes out zero-extended
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            word_q <= '0;
        end else if (capture) begin
            word_q[pos +: NW] <= sio_i;
        end
    end

    assign word_o = word_q;
    assign done_o = done_q;

endmodule

// File: hw/spi_mem_seq.sv
`timescale 1ns/1ps

module spi_mem_seq #(
    parameter logic [31:0] BASE_ADDR  = 32'h0000_0000,
    parameter logic [31:0] MEM_BYTES  = 32'h0400_0000,
    parameter int unsigned LAT_CLOCKS = spi_mem_pkg::DEF_LAT_CLOCKS
) (
    input  logic                           clk_i,
    input  logic                           nrst_i,

    input  logic                           req_i,
    input  spi_mem_pkg::mem_req_t          req_data_i,
    output logic                           ack_o,
    output spi_mem_pkg::mem_rsp_t          rsp_o,

    output logic                           spi_clk_o,
    output logic                           spi_cs_o,
    output logic                           spi_sio_oe_o,

    output logic                           tx_load_o,
    output logic [spi_mem_pkg::DATA_W-1:0] tx_frame_o,
    output logic [3:0]                     tx_count_o,
    input  logic                           tx_done_i,

    output logic                           rx_start_o,
    output logic [3:0]                     rx_count_o,
    input  logic                           rx_done_i,
    input  logic [spi_mem_pkg::DATA_W-1:0] rx_word_i
);

    localparam int unsigned AW      = spi_mem_pkg::ADDR_W;
    localparam int unsigned DW      = spi_mem_pkg::DATA_W;
    localparam int unsigned LAT_CYC = 2 * LAT_CLOCKS;
    localparam int unsigned LAT_W   = ($clog2(LAT_CYC) > 0) ? $clog2(LAT_CYC) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SETUP,
        ST_CMD,
        ST_ADDR,
        ST_LAT,
        ST_WDATA,
        ST_RDATA,
        ST_RESP
    } seq_state_e;

    seq_state_e               state_q;
    logic [LAT_W-1:0]         lat_cnt_q;
    spi_mem_pkg::mem_req_t    req_q;

    logic [31:0]              addr_wide;
    logic [31:0]              rel_addr;
    logic                     in_window;
    logic                     lat_last;
    logic [7:0]               cmd;
    logic [3:0]               data_nibs;
    logic [DW-1:0]            wdata_frame;
    spi_mem_pkg::addr_frame_u addr_frame;

    // window check on the raw bus address
    assign addr_wide = {{(32 - AW){1'b0}}, req_data_i.addr};
    assign rel_addr  = addr_wide - BASE_ADDR;
    assign in_window = (addr_wide >= BASE_ADDR) && (rel_addr < MEM_BYTES);

    assign lat_last  = (lat_cnt_q == '0);
    assign cmd       = req_q.we ? spi_mem_pkg::CMD_WRITE : spi_mem_pkg::CMD_READ;
    assign data_nibs = (req_q.size == spi_mem_pkg::SIZE_WORD) ? 4'd8 : 4'd2;

    // byte 0 leads on the wire
    assign wdata_frame = {req_q.wdata[7:0], req_q.wdata[15:8],
                          req_q.wdata[23:16], req_q.wdata[31:24]};

    always_comb begin
        addr_frame            = '0;
        addr_frame.fields.row = req_q.addr[AW-1:10];
        addr_frame.fields.col = req_q.addr[9:0];
    end

    // next frame is loaded while the shifter holds its last nibble
    always_comb begin
        tx_load_o  = 1'b0;
        tx_frame_o = '0;
        tx_count_o = '0;
        case (state_q)
            ST_SETUP: begin
                tx_load_o  = 1'b1;
                tx_frame_o = {cmd, {(DW - 8){1'b0}}};
                tx_count_o = 4'd2;
            end
            ST_CMD: begin
                tx_load_o  = tx_done_i;
                tx_frame_o = addr_frame;
                tx_count_o = 4'd8;
            end
            ST_LAT: begin
                tx_load_o  = req_q.we && lat_last;
                tx_frame_o = wdata_frame;
                tx_count_o = data_nibs;
            end
            default: begin
            end
        endcase
    end

    // gatherer is armed for the whole latency gap
    assign rx_start_o = (state_q == ST_ADDR) && tx_done_i && !req_q.we;
    assign rx_count_o = data_nibs;

    always_ff @(posedge clk_i) begin
        if ((state_q == ST_IDLE) && req_i) begin
            req_q <= '{addr:  rel_addr[AW-1:0],
                       we:    req_data_i.we,
                       size:  req_data_i.size,
                       wdata: req_data_i.wdata};
        end
    end

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state_q      <= ST_IDLE;
            lat_cnt_q    <= '0;
            ack_o        <= 1'b0;
            rsp_o        <= '0;
            spi_cs_o     <= 1'b1;
            spi_sio_oe_o <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        if (in_window) begin
                            state_q <= ST_SETUP;
                        end else begin
                            // no SPI traffic for a miss
                            ack_o   <= 1'b1;
                            rsp_o   <= '{rdata: '0, err: 1'b1};
                            state_q <= ST_RESP;
                        end
                    end
                end
                ST_SETUP: begin
                    spi_cs_o     <= 1'b0;
                    spi_sio_oe_o <= 1'b1;
                    state_q      <= ST_CMD;
                end
                ST_CMD: begin
                    if (tx_done_i) begin
                        state_q <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (tx_done_i) begin
                        lat_cnt_q <= LAT_W'(LAT_CYC - 1);
                        // turn the bus around on reads
                        spi_sio_oe_o <= req_q.we;
                        state_q      <= ST_LAT;
                    end
                end
                ST_LAT: begin
                    if (lat_last) begin
                        state_q <= req_q.we ? ST_WDATA : ST_RDATA;
                    end else begin
                        lat_cnt_q <= lat_cnt_q - 1'b1;
                    end
                end
                ST_WDATA: begin
                    if (tx_done_i) begin
                        spi_cs_o     <= 1'b1;
                        spi_sio_oe_o <= 1'b0;
                        ack_o        <= 1'b1;
                        rsp_o        <= '0;
                        state_q      <= ST_RESP;
                    end
                end
                ST_RDATA: begin
                    if (rx_done_i) begin
                        spi_cs_o <= 1'b1;
                        ack_o    <= 1'b1;
                        rsp_o    <= '{rdata: rx_word_i, err: 1'b0};
                        state_q  <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    // hold the response until the master lets go
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // SPI edges land mid-nibble
    always_ff @(negedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            spi_clk_o <= 1'b0;
        end else if (!spi_cs_o) begin
            spi_clk_o <= !spi_clk_o;
        end else begin
            spi_clk_o <= 1'b0;
        end
    end

endmodule

// File: hw/spi_mem_top.sv
`timescale 1ns/1ps

module spi_mem_top #(
    parameter logic [31:0] BASE_ADDR  = 32'h0000_0000,
    parameter logic [31:0] MEM_BYTES  = 32'h0400_0000,
    parameter int unsigned LAT_CLOCKS = spi_mem_pkg::DEF_LAT_CLOCKS
) (
    input  logic                          clk_i,
    input  logic                          nrst_i,

    input  logic                          req_i,
    input  spi_mem_pkg::mem_req_t         req_data_i,
    output logic                          ack_o,
    output spi_mem_pkg::mem_rsp_t         rsp_o,

    output logic                          spi_clk_o,
    output logic                          spi_cs_o,
    output logic [spi_mem_pkg::NIB_W-1:0] spi_sio_o,
    output logic                          spi_sio_oe_o,
    input  logic [spi_mem_pkg::NIB_W-1:0] spi_sio_i,
    input  logic                          spi_dqs_i
);

    logic                           tx_load;
    logic [spi_mem_pkg::DATA_W-1:0] tx_frame;
    logic [3:0]                     tx_count;
    logic                           tx_done;

    logic                           rx_start;
    logic [3:0]                     rx_count;
    logic                           rx_done;
    logic [spi_mem_pkg::DATA_W-1:0] rx_word;

    spi_mem_seq #(
        .BASE_ADDR  (BASE_ADDR),
        .MEM_BYTES  (MEM_BYTES),
        .LAT_CLOCKS (LAT_CLOCKS)
    ) seq_inst (
        .clk_i        (clk_i),
        .nrst_i       (nrst_i),
        .req_i        (req_i),
        .req_data_i   (req_data_i),
        .ack_o        (ack_o),
        .rsp_o        (rsp_o),
        .spi_clk_o    (spi_clk_o),
        .spi_cs_o     (spi_cs_o),
        .spi_sio_oe_o (spi_sio_oe_o),
        .tx_load_o    (tx_load),
        .tx_frame_o   (tx_frame),
        .tx_count_o   (tx_count),
        .tx_done_i    (tx_done),
        .rx_start_o   (rx_start),
        .rx_count_o   (rx_count),
        .rx_done_i    (rx_done),
        .rx_word_i    (rx_word)
    );

    spi_tx_shifter tx_inst (
        .clk_i   (clk_i),
        .nrst_i  (nrst_i),
        .load_i  (tx_load),
        .frame_i (tx_frame),
        .count_i (tx_count),
        .sio_o   (spi_sio_o),
        .done_o  (tx_done)
    );

    spi_rx_gather rx_inst (
        .clk_i   (clk_i),
        .nrst_i  (nrst_i),
        .start_i (rx_start),
        .count_i (rx_count),
        .sio_i   (spi_sio_i),
        .dqs_i   (spi_dqs_i),
        .word_o  (rx_word),
        .done_o  (rx_done)
    );

endmodule

// File: dv/psram_model.sv
`timescale 1ns/1ps

module psram_model #(
    parameter int unsigned MEM_BYTES  = 1024,
    parameter int unsigned LAT_CLOCKS = spi_mem_pkg::DEF_LAT_CLOCKS
) (
    input  logic       spi_clk_i,
    input  logic       spi_cs_i,
    input  logic [3:0] sio_i,
    input  logic       sio_oe_i,
    output logic [3:0] sio_o,
    output logic       dqs_o
);

    // spi edges ahead of the first data nibble
    localparam int unsigned DATA_EDGE = 2 + 8 + 2 * LAT_CLOCKS;

    logic [7:0]               mem [MEM_BYTES];
    logic [7:0]               cmd;
    spi_mem_pkg::addr_frame_u frame;
    int unsigned              edge_cnt = 0;
    int unsigned              byte_addr;
    int unsigned              nib_idx;
    int unsigned              cur;
    logic [3:0]               line;
    logic [3:0]               wr_hi;
    logic [3:0]               sio_q = '0;
    logic                     dqs_q = 1'b0;

    initial begin : fill_memory
        int unsigned a;
        for (a = 0; a < MEM_BYTES; a++) begin
            mem[a] = 8'((a * 37) ^ (a >> 8));
        end
    end

    always @(posedge spi_clk_i or negedge spi_clk_i or posedge spi_cs_i) begin
        if (spi_cs_i) begin
            edge_cnt = 0;
            dqs_q    <= 1'b0;
            sio_q    <= '0;
        end else begin
            // undriven lines float high
            line = sio_oe_i ? sio_i : 4'hF;
            if (edge_cnt < 2) begin
                cmd = {cmd[3:0], line};
            end else if (edge_cnt < 10) begin
                frame.nib[3'(9 - edge_cnt)] = line;
                byte_addr = 32'({frame.fields.row, frame.fields.col});
            end else if (edge_cnt >= DATA_EDGE) begin
                nib_idx = edge_cnt - DATA_EDGE;
                cur     = (byte_addr + nib_idx / 2) % MEM_BYTES;
                if (cmd == spi_mem_pkg::CMD_WRITE) begin
                    if (nib_idx[0] == 1'b0) begin
                        wr_hi = line;
                    end else begin
                        mem[cur] = {wr_hi, line};
                    end
                end else if (cmd == spi_mem_pkg::CMD_READ) begin
                    // high nibble of each byte first
                    dqs_q <= 1'b1;
                    sio_q <= nib_idx[0] ? mem[cur][3:0] : mem[cur][7:4];
                end
            end
            edge_cnt++;
        end
    end

    assign sio_o = sio_q;
    assign dqs_o = dqs_q;

endmodule

// File: dv/tb_spi_mem.sv
`timescale 1ns/1ps

module tb_spi_mem;

    localparam logic [31:0] BASE_ADDR  = 32'h0000_0000;
    localparam int unsigned MEM_BYTES  = 1024;
    localparam int unsigned LAT_CLOCKS = spi_mem_pkg::DEF_LAT_CLOCKS;
    localparam int unsigned N_RANDOM   = 40;
    // seven directed requests run ahead of the random ones
    localparam int unsigned MAX_CYCLES = 16 + 64 * (N_RANDOM + 7);

    logic                  clk;
    logic                  nrst;
    logic                  req;
    spi_mem_pkg::mem_req_t req_data;
    logic                  ack;
    spi_mem_pkg::mem_rsp_t rsp;
    logic                  spi_clk;
    logic                  spi_cs;
    logic                  spi_oe;
    logic                  spi_dqs;
    logic [3:0]            sio_to_ram;
    logic [3:0]            sio_from_ram;

    logic [7:0]            shadow [MEM_BYTES];
    spi_mem_pkg::mem_rsp_t exp_q [$];
    logic [31:0]           lfsr = 32'h653e;
    int unsigned           cycles = 0;
    int unsigned           n_issued = 0;
    int unsigned           n_checked = 0;
    logic                  outside_window = 1'b0;

    spi_mem_top #(
        .BASE_ADDR  (BASE_ADDR),
        .MEM_BYTES  (32'(MEM_BYTES)),
        .LAT_CLOCKS (LAT_CLOCKS)
    ) spi_mem_top_inst (
        .clk_i        (clk),
        .nrst_i       (nrst),
        .req_i        (req),
        .req_data_i   (req_data),
        .ack_o        (ack),
        .rsp_o        (rsp),
        .spi_clk_o    (spi_clk),
        .spi_cs_o     (spi_cs),
        .spi_sio_o    (sio_to_ram),
        .spi_sio_oe_o (spi_oe),
        .spi_sio_i    (sio_from_ram),
        .spi_dqs_i    (spi_dqs)
    );

    psram_model #(
        .MEM_BYTES  (MEM_BYTES),
        .LAT_CLOCKS (LAT_CLOCKS)
    ) psram_inst (
        .spi_clk_i (spi_clk),
        .spi_cs_i  (spi_cs),
        .sio_i     (sio_to_ram),
        .sio_oe_i  (spi_oe),
        .sio_o     (sio_from_ram),
        .dqs_o     (spi_dqs)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] want);
        assert (got == want)
        else report_failure($sformatf("MISMATCH t=%0t %s got %0h exp %0h",
                                      $time, name, got, want));
    endtask

    // fibonacci lfsr on taps 32 22 2 1 stepping once per bit
    function automatic logic [31:0] take_bits(input int unsigned n);
        logic [31:0] v;
        logic        fb;
        int unsigned i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int unsigned byte_count(input spi_mem_pkg::bus_size_e size);
        return (size == spi_mem_pkg::SIZE_WORD) ? 4 : 1;
    endfunction

    // expected response from the shadow with byte 0 in the low lane
    function automatic spi_mem_pkg::mem_rsp_t expect_rsp(input spi_mem_pkg::mem_req_t r);
        spi_mem_pkg::mem_rsp_t want;
        int unsigned           a;
        int unsigned           k;
        want = '0;
        a    = 32'(r.addr) - BASE_ADDR;
        if (a >= MEM_BYTES) begin
            want.err = 1'b1;
        end else if (!r.we) begin
            for (k = 0; k < byte_count(r.size); k++) begin
                want.rdata[8*k +: 8] = shadow[a + k];
            end
        end
        return want;
    endfunction

    task automatic shadow_write(input spi_mem_pkg::mem_req_t r);
        int unsigned a;
        int unsigned k;
        a = 32'(r.addr) - BASE_ADDR;
        if (r.we && a < MEM_BYTES) begin
            for (k = 0; k < byte_count(r.size); k++) begin
                shadow[a + k] = r.wdata[8*k +: 8];
            end
        end
    endtask

    task automatic run_txn(input spi_mem_pkg::mem_req_t r);
        spi_mem_pkg::mem_rsp_t want;
        int unsigned           delay;
        delay = take_bits(3);
        want  = expect_rsp(r);
        exp_q.push_back(want);
        outside_window = want.err;
        shadow_write(r);
        n_issued++;
        @(posedge clk);
        req_data <= r;
        req      <= 1'b1;
        do begin
            @(posedge clk);
        end while (!ack);
        // master lingers while the response holds
        repeat (delay) begin
            @(posedge clk);
            check_val("ack_o", 64'(ack), 64'd1);
            check_val("rsp_o", 64'(rsp), 64'(want));
        end
        req <= 1'b0;
        repeat (2) @(posedge clk);
        check_val("ack_o", 64'(ack), 64'd0);
        outside_window = 1'b0;
    endtask

    initial begin : compare_responses
        spi_mem_pkg::mem_rsp_t want;
        forever begin
            @(posedge ack);
            // sample half a cycle after ack rises
            @(negedge clk);
            assert (exp_q.size() != 0)
            else report_failure("ack_o rose with no request outstanding");
            want = exp_q.pop_front();
            check_val("rsp_o.err", 64'(rsp.err), 64'(want.err));
            check_val("rsp_o.rdata", 64'(rsp.rdata), 64'(want.rdata));
            n_checked++;
        end
    end

    always @(negedge spi_cs) begin
        assert (!outside_window)
        else report_failure("spi_cs_o went low for an out-of-window request");
    end

    always @(posedge clk) begin
        cycles++;
        assert (!(spi_dqs && spi_oe))
        else report_failure("controller drives SIO while the RAM drives DQS");
        if (cycles >= MAX_CYCLES) begin
            report_failure($sformatf("timeout, run not finished after %0d cycles", cycles));
        end
    end

    initial begin : stimulus
        spi_mem_pkg::mem_req_t r;
        int unsigned           i;
        nrst     = 1'b0;
        req      = 1'b0;
        req_data = '0;
        for (i = 0; i < MEM_BYTES; i++) begin
            shadow[i] = 8'((i * 37) ^ (i >> 8));
        end
        repeat (16) @(posedge clk);
        nrst <= 1'b1;
        repeat (2) @(posedge clk);
        check_val("spi_cs_o", 64'(spi_cs), 64'd1);
        check_val("ack_o", 64'(ack), 64'd0);
        check_val("spi_clk_o", 64'(spi_clk), 64'd0);
        check_val("spi_sio_oe_o", 64'(spi_oe), 64'd0);

        r = '{addr: 26'h40, we: 1'b1, size: spi_mem_pkg::SIZE_WORD, wdata: 32'hA5C3_1E7B};
        run_txn(r);
        r.we = 1'b0;
        run_txn(r);
        // single byte into lane 2 and read back as word and byte
        r = '{addr: 26'h42, we: 1'b1, size: spi_mem_pkg::SIZE_BYTE, wdata: 32'h0000_005D};
        run_txn(r);
        r = '{addr: 26'h40, we: 1'b0, size: spi_mem_pkg::SIZE_WORD, wdata: 32'h0};
        run_txn(r);
        r = '{addr: 26'h42, we: 1'b0, size: spi_mem_pkg::SIZE_BYTE, wdata: 32'h0};
        run_txn(r);
        r = '{addr: 26'(MEM_BYTES), we: 1'b0, size: spi_mem_pkg::SIZE_WORD, wdata: 32'h0};
        run_txn(r);
        r = '{addr: 26'h3FF_FFFC, we: 1'b1, size: spi_mem_pkg::SIZE_WORD, wdata: 32'hFFFF_FFFF};
        run_txn(r);

        for (i = 0; i < N_RANDOM; i++) begin
            r.we    = 1'(take_bits(1));
            r.size  = (take_bits(1) == 32'd1) ? spi_mem_pkg::SIZE_WORD : spi_mem_pkg::SIZE_BYTE;
            r.wdata = take_bits(32);
            if (take_bits(3) == 32'd0) begin
                r.addr = 26'(BASE_ADDR + MEM_BYTES + take_bits(16));
            end else begin
                r.addr = 26'(BASE_ADDR + take_bits($clog2(MEM_BYTES)));
                if (r.size == spi_mem_pkg::SIZE_WORD) begin
                    r.addr[1:0] = 2'b00;
                end
            end
            run_txn(r);
        end

        repeat (2) @(posedge clk);
        if (n_checked == n_issued) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_failure($sformatf("%0d requests issued but %0d responses checked",
                                     n_issued, n_checked));
        end
    end

endmodule

// File: flist.f
hw/spi_mem_pkg.sv
hw/spi_tx_shifter.sv
hw/spi_rx_gather.sv
hw/spi_mem_seq.sv
hw/spi_mem_top.sv
dv/psram_model.sv
dv/tb_spi_mem.sv

// File: Makefile
VERILATOR       ?= verilator
TOP             ?= tb_spi_mem
FLIST           ?= flist.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
